// ==== smpc_macros.svh ====
`ifndef SMPC_MACROS_SVH
`define SMPC_MACROS_SVH

// Host bus word addresses
`define SMPC_A_IREG0      6'h00
`define SMPC_A_COMREG     6'h0F
`define SMPC_A_OREG0      6'h10
`define SMPC_A_SR         6'h30
`define SMPC_A_SF         6'h31

// Sequencer wait times in clock cycles
`define SMPC_ACCEPT_WAIT  16'd60
`define SMPC_WAIT_PWR     16'd60
`define SMPC_WAIT_CD      16'd100
`define SMPC_WAIT_NMI     16'd70
`define SMPC_WAIT_TIME    16'd220
`define SMPC_STATUS_GAP   16'd50

`define SMPC_OREG_DEPTH   32
`define SMPC_OREG_LAST    5'd31

`endif

// ==== smpc_cmd_pkg.sv ====
package smpc_cmd_pkg;

	typedef enum logic [7:0] {
		MSHON   = 8'h00,
		SSHON   = 8'h02,
		SSHOFF  = 8'h03,
		SNDON   = 8'h06,
		SNDOFF  = 8'h07,
		CDON    = 8'h08,
		CDOFF   = 8'h09,
		INTBACK = 8'h10,
		SETTIME = 8'h16,
		NMIREQ  = 8'h18,
		RESENAB = 8'h19,
		RESDISA = 8'h1A
	} cmd_code_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		COMMAND,
		STATUS,
		EXEC,
		END
	} seq_state_t;

	// IREG0 to IREG6
	typedef logic [7:0] ireg_t [7];

endpackage

// ==== smpc_rtc_pkg.sv ====
package smpc_rtc_pkg;

	// Calendar as seen by INTBACK with year first
	typedef struct packed {
		logic [15:0] year;  // BCD
		logic [3:0]  wday;
		logic [3:0]  month; // Binary 1 to 12
		logic [7:0]  days;
		logic [7:0]  hour;
		logic [7:0]  min;
		logic [7:0]  sec;
	} rtc_time_t;

endpackage

// ==== smpc_if.sv ====
`timescale 1ns/1ps

interface smpc_cmd_if;
	import smpc_cmd_pkg::*;

	logic       cmd_valid;
	logic       cmd_ready;
	cmd_code_t  cmd_code;
	ireg_t      ireg;
	logic       done;
	logic [7:0] sr;

	modport regs (output cmd_valid, cmd_code, ireg, input cmd_ready, done, sr);
	modport seq (input cmd_valid, cmd_code, ireg, output cmd_ready, done, sr);
endinterface

interface smpc_oreg_if;
	logic       we;
	logic [4:0] waddr;
	logic [7:0] wdata;
	logic [4:0] raddr;
	logic [7:0] rdata;

	modport wr (output we, waddr, wdata);
	modport mem (input we, waddr, wdata, raddr, output rdata);
	modport rd (output raddr, input rdata);
endinterface

// ==== smpc_host_regs.sv ====
`timescale 1ns/1ps
`include "smpc_macros.svh"

module smpc_host_regs (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [5:0] bus_addr,
	input  logic [7:0] bus_wdata,
	input  logic       bus_wr,
	input  logic       bus_rd,
	output logic [7:0] bus_rdata,
	smpc_cmd_if.regs   cmd,
	smpc_oreg_if.rd    oreg
);
	import smpc_cmd_pkg::*;

	ireg_t      ireg;
	cmd_code_t  comreg;
	logic       pending;
	logic       sf;
	logic [7:0] sr;
	logic [5:0] ireg_idx;
	logic [5:0] oreg_off;
	logic       oreg_hit;

	assign ireg_idx = bus_addr - `SMPC_A_IREG0;
	assign oreg_off = bus_addr - `SMPC_A_OREG0;
	assign oreg_hit = (bus_addr >= `SMPC_A_OREG0) &&
		(bus_addr <= `SMPC_A_OREG0 + `SMPC_OREG_LAST);

	assign oreg.raddr = oreg_off[4:0];
	assign cmd.cmd_valid = pending;
	assign cmd.cmd_code = comreg;
	assign cmd.ireg = ireg;

	always_ff @(posedge CLK) begin
		if (bus_wr && ireg_idx < 6'd7)
			ireg[ireg_idx[2:0]] <= bus_wdata;
		if (bus_wr && bus_addr == `SMPC_A_COMREG)
			comreg <= cmd_code_t'(bus_wdata); // Unknown codes kept as is
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			pending <= 1'b0;
			sf <= 1'b0;
			sr <= 8'h00;
		end else begin
			if (cmd.cmd_valid && cmd.cmd_ready)
				pending <= 1'b0;
			if (cmd.done) begin
				sf <= 1'b0;
				sr <= cmd.sr;
			end
			if (bus_wr && bus_addr == `SMPC_A_COMREG)
				pending <= 1'b1;  // Later write replaces a pending code
			if (bus_wr && bus_addr == `SMPC_A_SF && bus_wdata[0])
				sf <= 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N)
			bus_rdata <= 8'h00;
		else if (bus_rd) begin
			if (oreg_hit)
				bus_rdata <= oreg.rdata;
			else if (bus_addr == `SMPC_A_SR)
				bus_rdata <= sr;
			else if (bus_addr == `SMPC_A_SF)
				bus_rdata <= {7'b1111000, sf};
			else
				bus_rdata <= 8'h00;
		end
	end

endmodule

// ==== smpc_oreg_ram.sv ====
`timescale 1ns/1ps
`include "smpc_macros.svh"

module smpc_oreg_ram #(
	parameter int DEPTH = `SMPC_OREG_DEPTH
) (
	input  logic     CLK,
	smpc_oreg_if.mem oreg
);

	logic [7:0] mem [DEPTH];

	always_ff @(posedge CLK) begin
		if (oreg.we)
			mem[oreg.waddr] <= oreg.wdata;
	end

	// Host side reads without a clock
	assign oreg.rdata = mem[oreg.raddr];

endmodule

// ==== smpc_cmd_seq.sv ====
`timescale 1ns/1ps
`include "smpc_macros.svh"

module smpc_cmd_seq (
	input  logic                     CLK,
	input  logic                     RST_N,
	smpc_cmd_if.seq                  cmd,
	smpc_oreg_if.wr                  oreg,
	input  logic [3:0]               ac,
	input  smpc_rtc_pkg::rtc_time_t  rtc_now,
	output logic                     rtc_load,
	output smpc_rtc_pkg::rtc_time_t  rtc_set,
	output logic                     mshres_n,
	output logic                     mshnmi_n,
	output logic                     sshres_n,
	output logic                     sshnmi_n,
	output logic                     sndres_n,
	output logic                     cdres_n,
	output logic                     mirq_n
);
	import smpc_cmd_pkg::*;

	seq_state_t  state;
	seq_state_t  next_st;
	logic [15:0] wait_cnt;
	logic [4:0]  oreg_cnt;
	cmd_code_t   code_q;
	logic        resd;
	logic        ste;
	logic [7:0]  sr_q;
	logic [7:0]  status_byte;
	logic        status_req;

	assign cmd.cmd_ready = (state == IDLE);
	assign cmd.done = (state == END);
	assign cmd.sr = sr_q;
	assign status_req = (cmd.ireg[2] == 8'hF0) && cmd.ireg[0][0];

	// IREG0:IREG1 year, IREG2 wday/month, IREG3..6 days to sec
	assign rtc_set = {cmd.ireg[0], cmd.ireg[1], cmd.ireg[2], cmd.ireg[3],
		cmd.ireg[4], cmd.ireg[5], cmd.ireg[6]};
	assign rtc_load = (state == EXEC) && (code_q == SETTIME);

	always_comb begin
		case (oreg_cnt)
			5'd0:    status_byte = {ste, resd, 6'b000000};
			5'd1:    status_byte = rtc_now.year[15:8];
			5'd2:    status_byte = rtc_now.year[7:0];
			5'd3:    status_byte = {rtc_now.wday, rtc_now.month};
			5'd4:    status_byte = rtc_now.days;
			5'd5:    status_byte = rtc_now.hour;
			5'd6:    status_byte = rtc_now.min;
			5'd7:    status_byte = rtc_now.sec;
			5'd9:    status_byte = {4'b0000, ac};
			5'd10:   status_byte = {4'b0011, ~mshnmi_n, 2'b11, ~sndres_n};
			5'd11:   status_byte = {1'b0, ~cdres_n, 6'b000000};
			default: status_byte = 8'h00;
		endcase
	end

	assign oreg.we = (state == STATUS) || (state == EXEC);
	assign oreg.waddr = (state == EXEC) ? `SMPC_OREG_LAST : oreg_cnt;
	assign oreg.wdata = (state == EXEC) ? code_q : status_byte; // Code echo in OREG31

	always_ff @(posedge CLK) begin
		if (cmd.cmd_valid && cmd.cmd_ready)
			code_q <= cmd.cmd_code;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= IDLE;
			next_st <= IDLE;
			wait_cnt <= 16'd0;
			oreg_cnt <= 5'd0;
			resd <= 1'b1;
			ste <= 1'b0;
			sr_q <= 8'h00;
			mshres_n <= 1'b0;
			mshnmi_n <= 1'b0;
			sshres_n <= 1'b0;
			sshnmi_n <= 1'b0;
			sndres_n <= 1'b0;
			cdres_n <= 1'b0;
			mirq_n <= 1'b1;
		end else begin
			case (state)
				IDLE: if (cmd.cmd_valid) begin
					oreg_cnt <= 5'd0;
					wait_cnt <= `SMPC_ACCEPT_WAIT;
					next_st <= COMMAND;
					state <= WAIT;
				end
				WAIT: begin
					wait_cnt <= wait_cnt - 16'd1;
					if (wait_cnt <= 16'd1)
						state <= next_st;
				end
				COMMAND: begin
					next_st <= EXEC;
					state <= WAIT;
					case (code_q)
						MSHON, SSHON, SSHOFF, SNDON, SNDOFF: wait_cnt <= `SMPC_WAIT_PWR;
						CDON, CDOFF:               wait_cnt <= `SMPC_WAIT_CD;
						NMIREQ, RESENAB, RESDISA:  wait_cnt <= `SMPC_WAIT_NMI;
						SETTIME:                   wait_cnt <= `SMPC_WAIT_TIME;
						INTBACK: state <= status_req ? STATUS : END;
						default: state <= EXEC;  // Unknown code only echoed
					endcase
				end
				STATUS: begin
					oreg_cnt <= oreg_cnt + 5'd1;
					wait_cnt <= `SMPC_STATUS_GAP;
					next_st <= (oreg_cnt == 5'd15) ? EXEC : STATUS;
					state <= WAIT;
				end
				EXEC: begin
					state <= END;
					case (code_q)
						MSHON: begin
							mshres_n <= 1'b1;
							mshnmi_n <= 1'b1;
						end
						SSHON: begin
							sshres_n <= 1'b1;
							sshnmi_n <= 1'b1;
						end
						SSHOFF:  sshres_n <= 1'b0;
						SNDON:   sndres_n <= 1'b1;
						SNDOFF:  sndres_n <= 1'b0;
						CDON:    cdres_n <= 1'b1;
						CDOFF:   cdres_n <= 1'b0;
						NMIREQ:  mshnmi_n <= 1'b0;  // Released again in END
						RESENAB: resd <= 1'b0;
						RESDISA: resd <= 1'b1;
						SETTIME: ste <= 1'b1;
						INTBACK: begin
							sr_q <= 8'h4F;
							mirq_n <= 1'b0;
						end
						default: ;
					endcase
				end
				END: begin
					mirq_n <= 1'b1;
					if (code_q == NMIREQ)
						mshnmi_n <= 1'b1;
					state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== smpc_rtc.sv ====
`timescale 1ns/1ps

module smpc_rtc #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic                    CLK,
	input  logic                    RST_N,
	input  logic                    load,
	input  smpc_rtc_pkg::rtc_time_t set_time,
	output smpc_rtc_pkg::rtc_time_t now
);
	import smpc_rtc_pkg::*;

	localparam int DIV_W = $clog2(TICKS_PER_SEC);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(TICKS_PER_SEC - 1);
	localparam rtc_time_t RESET_TIME = {16'h2024, 4'h0, 4'd1, 8'h01, 8'h00, 8'h00, 8'h00};

	logic [DIV_W-1:0] div_cnt;
	logic             sec_tick;
	logic             sec_wrap;
	logic             min_wrap;
	logic             hour_wrap;
	logic             day_wrap;
	logic             month_wrap;
	logic [7:0]       last_day;
	logic [15:0]      year_inc;

	function automatic logic [7:0] bcd_inc(input logic [7:0] v);
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return {v[7:4], v[3:0] + 4'd1};
	endfunction

	always_comb begin
		case (now.month)
			4'd2:                      last_day = 8'h28;
			4'd4, 4'd6, 4'd9, 4'd11:  last_day = 8'h30;
			default:                   last_day = 8'h31;
		endcase
	end

	// Carry chain settles in the tick cycle
	assign sec_tick = (div_cnt == DIV_LAST);
	assign sec_wrap = sec_tick && now.sec == 8'h59;
	assign min_wrap = sec_wrap && now.min == 8'h59;
	assign hour_wrap = min_wrap && now.hour == 8'h23;
	assign day_wrap = hour_wrap && now.days == last_day;
	assign month_wrap = day_wrap && now.month == 4'd12;

	assign year_inc[7:0] = (now.year[7:0] == 8'h99) ? 8'h00 : bcd_inc(now.year[7:0]);
	assign year_inc[15:8] = (now.year[7:0] == 8'h99) ? bcd_inc(now.year[15:8]) :
		now.year[15:8];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			now <= RESET_TIME;
		end else if (load) begin
			div_cnt <= '0;  // First second counts from the load
			now <= set_time;
		end else begin
			div_cnt <= sec_tick ? '0 : div_cnt + 1'b1;
			if (sec_tick)
				now.sec <= sec_wrap ? 8'h00 : bcd_inc(now.sec);
			if (sec_wrap)
				now.min <= min_wrap ? 8'h00 : bcd_inc(now.min);
			if (min_wrap)
				now.hour <= hour_wrap ? 8'h00 : bcd_inc(now.hour);
			if (hour_wrap)
				now.days <= day_wrap ? 8'h01 : bcd_inc(now.days);
			if (day_wrap)
				now.month <= month_wrap ? 4'd1 : now.month + 4'd1;
			if (month_wrap)
				now.year <= year_inc;
		end
	end

endmodule

// ==== smpc_top.sv ====
`timescale 1ns/1ps
`include "smpc_macros.svh"

module smpc_top #(
	parameter int TICKS_PER_SEC = 4000000
) (
	input  logic       CLK,
	input  logic       RST_N,
	input  logic [5:0] bus_addr,
	input  logic [7:0] bus_wdata,
	input  logic       bus_wr,
	input  logic       bus_rd,
	output logic [7:0] bus_rdata,
	input  logic [3:0] ac,
	output logic       mshres_n,
	output logic       mshnmi_n,
	output logic       sshres_n,
	output logic       sshnmi_n,
	output logic       sndres_n,
	output logic       cdres_n,
	output logic       mirq_n
);
	import smpc_rtc_pkg::*;

	rtc_time_t rtc_now;
	rtc_time_t rtc_set;
	logic      rtc_load;

	smpc_cmd_if  cmd_bus ();
	smpc_oreg_if oreg_bus ();

	smpc_host_regs u_host_regs (
		.CLK(CLK), .RST_N(RST_N),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_wr(bus_wr), .bus_rd(bus_rd), .bus_rdata(bus_rdata),
		.cmd(cmd_bus), .oreg(oreg_bus)
	);

	smpc_oreg_ram #(.DEPTH(`SMPC_OREG_DEPTH)) u_oreg_ram (.CLK(CLK), .oreg(oreg_bus));

	smpc_cmd_seq u_cmd_seq (
		.CLK(CLK), .RST_N(RST_N), .cmd(cmd_bus), .oreg(oreg_bus), .ac(ac),
		.rtc_now(rtc_now), .rtc_load(rtc_load), .rtc_set(rtc_set),
		.mshres_n(mshres_n), .mshnmi_n(mshnmi_n), .sshres_n(sshres_n),
		.sshnmi_n(sshnmi_n), .sndres_n(sndres_n), .cdres_n(cdres_n), .mirq_n(mirq_n)
	);

	smpc_rtc #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_rtc (
		.CLK(CLK), .RST_N(RST_N), .load(rtc_load), .set_time(rtc_set), .now(rtc_now)
	);

endmodule

// ==== smpc_assert.sv ====
`timescale 1ns/1ps

module smpc_assert (
	input logic                     CLK,
	input logic                     RST_N,
	input smpc_cmd_pkg::seq_state_t state,
	input logic                     done,
	input logic                     cmd_ready,
	input logic                     we
);
	import smpc_cmd_pkg::*;

	a_done_pulse: assert property (@(posedge CLK) disable iff (!RST_N) done |=> !done)
		else $error("done high for two cycles in a row");

	a_ready_idle: assert property (@(posedge CLK) disable iff (!RST_N)
		cmd_ready |-> state == IDLE)
		else $error("cmd_ready high outside IDLE");

	// No OREG traffic while counting down
	a_no_we_wait: assert property (@(posedge CLK) disable iff (!RST_N) state == WAIT |-> !we)
		else $error("OREG write during WAIT");

endmodule

bind smpc_cmd_seq smpc_assert u_assert (
	.CLK(CLK), .RST_N(RST_N), .state(state), .done(cmd.done),
	.cmd_ready(cmd.cmd_ready), .we(oreg.we)
);

// ==== tb_smpc.sv ====
`timescale 1ns/1ps

module tb_smpc;

	localparam int POLL_LIMIT = 2000;
	localparam int RESET_CYCLES = 4;
	localparam logic [5:0] SF_ADDR = 6'h31;

	logic       CLK;
	logic       RST_N;
	logic [5:0] bus_addr;
	logic [7:0] bus_wdata;
	logic       bus_wr;
	logic       bus_rd;
	logic [7:0] bus_rdata;
	logic [3:0] ac;
	logic       mshres_n;
	logic       mshnmi_n;
	logic       sshres_n;
	logic       sshnmi_n;
	logic       sndres_n;
	logic       cdres_n;
	logic       mirq_n;
	logic [6:0] lines;

	byte         op_q[$];
	logic [15:0] a_q[$];
	logic [15:0] b_q[$];
	int          errors = 0;
	int          test_errors = 0;
	int          checks = 0;
	int          tests = 0;
	int          cycle_cnt = 0;
	int          cycle_limit = 32'h7fffffff;  // Set once the stimulus is known

	assign lines = {mshres_n, mshnmi_n, sshres_n, sshnmi_n, sndres_n, cdres_n, mirq_n};

	smpc_top #(.TICKS_PER_SEC(4000)) dut (
		.CLK(CLK), .RST_N(RST_N),
		.bus_addr(bus_addr), .bus_wdata(bus_wdata),
		.bus_wr(bus_wr), .bus_rd(bus_rd), .bus_rdata(bus_rdata), .ac(ac),
		.mshres_n(mshres_n), .mshnmi_n(mshnmi_n), .sshres_n(sshres_n),
		.sshnmi_n(sshnmi_n), .sndres_n(sndres_n), .cdres_n(cdres_n), .mirq_n(mirq_n)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Run stopped after %0d cycles without finishing", cycle_cnt);
			$display("TESTS FAILED");
			$finish;
		end
	end

	task automatic load_stimulus(output bit ok);
		int          fd;
		int          n;
		int          wait_sum;
		int          polls;
		string       line;
		byte         op;
		logic [15:0] a;
		logic [15:0] b;
		wait_sum = 0;
		polls = 0;
		fd = $fopen("smpc_stimulus.txt", "r");
		ok = (fd != 0);
		if (ok) begin
			while (!$feof(fd)) begin
				n = $fgets(line, fd);
				if (n > 1 && line.getc(0) != "#") begin
					a = '0;
					b = '0;
					n = $sscanf(line, "%c %h %h", op, a, b);
					if (op == "T")
						n = $sscanf(line, "%c %d", op, a);  // Cycle counts are decimal
					op_q.push_back(op);
					a_q.push_back(a);
					b_q.push_back(b);
					if (op == "T")
						wait_sum += a;
					if (op == "P")
						polls++;
				end
			end
			$fclose(fd);
			cycle_limit = RESET_CYCLES + wait_sum + polls * POLL_LIMIT + 4 * op_q.size() + 500;
		end
	endtask

	task automatic bus_write(input logic [5:0] addr, input logic [7:0] data);
		bus_addr = addr;
		bus_wdata = data;
		bus_wr = 1'b1;
		@(negedge CLK);
		bus_wr = 1'b0;
	endtask

	task automatic bus_read(input logic [5:0] addr, output logic [7:0] data);
		bus_addr = addr;
		bus_rd = 1'b1;
		@(negedge CLK);
		bus_rd = 1'b0;
		data = bus_rdata;  // Registered on the edge just past
	endtask

	task automatic check_read(input logic [5:0] addr, input logic [7:0] exp);
		logic [7:0] data;
		bus_read(addr, data);
		checks++;
		if (data !== exp) begin
			$display("ERROR t=%0t bus_rdata[%02h]: expected %02h, got %02h", $time, addr, exp, data);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_lines(input logic [6:0] exp);
		checks++;
		if (lines !== exp) begin
			$display("ERROR t=%0t reset lines: expected %02h, got %02h", $time, exp, lines);
			errors++;
			test_errors++;
		end
	endtask

	task automatic poll_sf();
		logic [7:0] data;
		int         n;
		data = 8'hFF;
		n = 0;
		while (data[0] !== 1'b0 && n < POLL_LIMIT) begin
			bus_read(SF_ADDR, data);
			n++;
		end
		checks++;
		if (data[0] !== 1'b0) begin
			$display("SF still set %0d cycles after the command at t=%0t", POLL_LIMIT, $time);
			errors++;
			test_errors++;
		end
	endtask

	task automatic end_test(input int num);
		tests++;
		if (test_errors == 0)
			$display("test %0d ok", num);
		else
			$display("test %0d failed with %0d errors", num, test_errors);
		test_errors = 0;
	endtask

	initial begin
		bit ok;
		RST_N = 1'b0;
		bus_addr = 6'h00;
		bus_wdata = 8'h00;
		bus_wr = 1'b0;
		bus_rd = 1'b0;
		ac = 4'hA;
		load_stimulus(ok);
		if (!ok) begin
			$display("Stimulus file smpc_stimulus.txt could not be opened");
			$display("TESTS FAILED");
			$finish;
		end else begin
			repeat (RESET_CYCLES) @(negedge CLK);
			RST_N = 1'b1;
			@(negedge CLK);
			for (int i = 0; i < op_q.size(); i++) begin
				case (op_q[i])
					"W": bus_write(a_q[i][5:0], b_q[i][7:0]);
					"R": check_read(a_q[i][5:0], b_q[i][7:0]);
					"P": poll_sf();
					"L": check_lines(a_q[i][6:0]);
					"T": repeat (a_q[i]) @(negedge CLK);
					"E": end_test(a_q[i]);
					default: begin
						$display("Unknown stimulus operation %c", op_q[i]);
						errors++;
					end
				endcase
			end
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0)
				$display("TESTS PASSED");
			else
				$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

// ==== smpc_stimulus.txt ====
# op a b: W addr data, R addr expected, P poll SF, L lines {mshres mshnmi sshres sshnmi sndres cdres mirq}
# T cycles in decimal, E test number; other values in hex
L 01
R 31 F0
E 1
W 0F 00
W 31 01
P
L 61
R 2F 00
W 0F 02
W 31 01
P
L 79
R 2F 02
W 0F 06
W 31 01
P
L 7D
R 2F 06
W 0F 08
W 31 01
P
L 7F
R 2F 08
W 0F 03
W 31 01
P
L 6F
R 2F 03
W 0F 07
W 31 01
P
L 6B
R 2F 07
W 0F 09
W 31 01
P
L 69
R 2F 09
E 2
W 0F 18
W 31 01
P
L 69
R 2F 18
W 0F 19
W 31 01
P
W 00 01
W 02 F0
W 0F 10
W 31 01
P
R 10 00
R 30 4F
W 0F 1A
W 31 01
P
W 0F 10
W 31 01
P
R 10 40
R 2F 10
L 69
E 3
W 00 19
W 01 99
W 02 02
W 03 28
W 04 23
W 05 59
W 06 59
W 0F 16
W 31 01
P
R 2F 16
W 02 F0
W 0F 10
W 31 01
P
R 10 C0
R 11 19
R 12 99
R 13 02
R 14 28
R 15 23
R 16 59
R 17 59
R 19 0A
E 4
T 4200
W 0F 10
W 31 01
P
R 11 19
R 12 99
R 13 03
R 14 01
R 15 00
R 16 00
R 17 00
R 1A 37
R 1B 40
E 5
W 0F 55
W 31 01
P
R 2F 55
L 69
E 6

// ==== build.f ====
+incdir+.
smpc_cmd_pkg.sv
smpc_rtc_pkg.sv
smpc_if.sv
smpc_host_regs.sv
smpc_oreg_ram.sv
smpc_cmd_seq.sv
smpc_rtc.sv
smpc_top.sv
smpc_assert.sv
tb_smpc.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_smpc
FILELIST  = build.f
LOG       = sim.log

.PHONY: all lint clean

all:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)
